/* hdl/dcachePkg.sv */
package dcachePkg;

  localparam int AddrWidth    = 32;
  localparam int WordWidth    = 64;
  localparam int LineWidth    = 256;
  localparam int BeatsPerLine = 4;
  localparam int Sets         = 64;
  localparam int OffsetWidth  = 5;
  localparam int IndexWidth   = 6;
  localparam int TagWidth     = 21;
  localparam int MaskWidth    = 8;

  // load/store request from the core side
  typedef struct packed {
    logic                 write;
    logic [AddrWidth-1:0] addr;
    logic [WordWidth-1:0] data;
    logic [MaskWidth-1:0] mask;
  } cacheReq_t;

  typedef struct packed {
    logic [WordWidth-1:0] data;
    logic                 write;
  } cacheResp_t;

  // per-set bookkeeping of one way
  typedef struct packed {
    logic                valid;
    logic                dirty;
    logic [TagWidth-1:0] tag;
  } tagEntry_t;

  typedef struct packed {
    logic                 hit;
    logic                 dirty;
    logic [TagWidth-1:0]  tag;
    logic [LineWidth-1:0] line;
  } wayLookup_t;

  // tagUpdate installs a fresh line, otherwise the write marks the set dirty
  typedef struct packed {
    logic                   en;
    logic [LineWidth-1:0]   line;
    logic [LineWidth/8-1:0] mask;
    logic                   tagUpdate;
  } wayWrite_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [LineWidth-1:0] line;
  } memReq_t;

  typedef enum logic [2:0] {IDLE, COMPARE, WRBACK, MISS, REFILL, REPLACE} cacheState_e;

endpackage

/* hdl/setArray.sv */
`timescale 1ns/1ps

module setArray import dcachePkg::*; #(
  parameter type EntryT = logic [7:0]
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [IndexWidth-1:0] rdIndex_i,
  output EntryT                 rdEntry_o,
  input  logic                  wrEn_i,
  input  logic [IndexWidth-1:0] wrIndex_i,
  input  EntryT                 wrEntry_i,
  input  EntryT                 wrMask_i
);

  EntryT mem [Sets];

  // combinational read port
  assign rdEntry_o = mem[rdIndex_i];

  // only the bits set in wrMask_i change
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < Sets; i++) begin
        mem[i] <= '0;
      end
    end else if (wrEn_i) begin
      mem[wrIndex_i] <= (mem[wrIndex_i] & ~wrMask_i) | (wrEntry_i & wrMask_i);
    end
  end

endmodule

/* hdl/cacheWay.sv */
`timescale 1ns/1ps

module cacheWay import dcachePkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [IndexWidth-1:0] index_i,
  input  logic [TagWidth-1:0]   tag_i,
  input  wayWrite_t             write_i,
  output wayLookup_t            lookup_o
);

  tagEntry_t              tagRd;
  tagEntry_t              tagWr;
  tagEntry_t              tagMask;
  logic [LineWidth-1:0]   lineRd;
  logic [LineWidth-1:0]   lineMask;

  // byte lanes to bit lanes
  always_comb begin
    for (int b = 0; b < LineWidth / 8; b++) begin
      lineMask[b*8 +: 8] = {8{write_i.mask[b]}};
    end
  end

  // refill writes a clean valid entry, a store only sets dirty
  always_comb begin
    tagWr.valid = 1'b1;
    tagWr.dirty = !write_i.tagUpdate;
    tagWr.tag   = tag_i;
    tagMask.valid = write_i.tagUpdate;
    tagMask.dirty = 1'b1;
    tagMask.tag   = {TagWidth{write_i.tagUpdate}};
  end

  setArray #(.EntryT(tagEntry_t)) tagArray_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rdIndex_i (index_i),
    .rdEntry_o (tagRd),
    .wrEn_i    (write_i.en),
    .wrIndex_i (index_i),
    .wrEntry_i (tagWr),
    .wrMask_i  (tagMask)
  );

  setArray #(.EntryT(logic [LineWidth-1:0])) dataArray_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rdIndex_i (index_i),
    .rdEntry_o (lineRd),
    .wrEn_i    (write_i.en),
    .wrIndex_i (index_i),
    .wrEntry_i (write_i.line),
    .wrMask_i  (lineMask)
  );

  assign lookup_o.hit   = tagRd.valid && (tagRd.tag == tag_i);
  assign lookup_o.dirty = tagRd.valid && tagRd.dirty;
  assign lookup_o.tag   = tagRd.tag;
  assign lookup_o.line  = lineRd;

endmodule

/* hdl/wayMerge.sv */
`timescale 1ns/1ps

module wayMerge import dcachePkg::*; (
  input  wayLookup_t                        way0_i,
  input  wayLookup_t                        way1_i,
  input  logic [$clog2(BeatsPerLine)-1:0]   wordSel_i,
  input  logic                              victimWay_i,
  output logic                              hit_o,
  output logic                              hitWay_o,
  output logic [WordWidth-1:0]              word_o,
  output wayLookup_t                        victim_o
);

  logic [LineWidth-1:0] hitLine;

  assign hit_o = way0_i.hit || way1_i.hit;

  // both ways never hit together, way 1 wins if they did
  assign hitWay_o = way1_i.hit;

  always_comb begin
    if (way1_i.hit) begin
      hitLine = way1_i.line;
    end else begin
      hitLine = way0_i.line;
    end
  end

  // word within the line by address bits 4..3
  always_comb begin
    word_o = hitLine[wordSel_i*WordWidth +: WordWidth];
  end

  // victim lookup for the dirty test and the write-back data
  always_comb begin
    if (victimWay_i) begin
      victim_o = way1_i;
    end else begin
      victim_o = way0_i;
    end
  end

endmodule

/* hdl/cacheCtrl.sv */
`timescale 1ns/1ps

module cacheCtrl import dcachePkg::*; (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            reqValid_i,
  input  cacheReq_t                       req_i,
  output logic                            reqReady_o,
  output logic                            respValid_o,
  output cacheResp_t                      resp_o,
  output logic [IndexWidth-1:0]           index_o,
  output logic [TagWidth-1:0]             tag_o,
  output logic [$clog2(BeatsPerLine)-1:0] wordSel_o,
  output logic                            victimWay_o,
  input  logic                            hit_i,
  input  logic                            hitWay_i,
  input  logic [WordWidth-1:0]            word_i,
  input  wayLookup_t                      victim_i,
  output wayWrite_t                       wayWrite0_o,
  output wayWrite_t                       wayWrite1_o,
  output logic                            memWrValid_o,
  output memReq_t                         memWr_o,
  input  logic                            memWrReady_i,
  output logic                            memRdValid_o,
  output logic [AddrWidth-1:0]            memRdAddr_o,
  input  logic                            memRdReady_i,
  input  logic [WordWidth-1:0]            memRdData_i,
  input  logic                            memRdBeat_i,
  input  logic                            memRdLast_i
);

  cacheState_e                      curState;
  cacheState_e                      nextState;
  cacheReq_t                        reqLatch;
  logic                             victimWay;
  logic [$clog2(BeatsPerLine)-1:0]  beatCnt;
  logic [LineWidth-1:0]             refillBuf;
  logic [WordWidth-1:0]             storeWord;
  logic [MaskWidth-1:0]             storeMask;
  logic [LineWidth-1:0]             storeLine;
  logic [LineWidth/8-1:0]           storeLineMask;
  logic [LineWidth-1:0]             wrLine;
  logic [LineWidth/8-1:0]           wrMask;
  logic                             replaceEn;
  logic                             storeHit;
  logic                             wrEn0;
  logic                             wrEn1;

  // fields of the latched address
  assign index_o     = reqLatch.addr[OffsetWidth +: IndexWidth];
  assign tag_o       = reqLatch.addr[AddrWidth-1 -: TagWidth];
  assign wordSel_o   = reqLatch.addr[OffsetWidth-1 -: $clog2(BeatsPerLine)];
  assign victimWay_o = victimWay;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= IDLE;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      IDLE: begin
        if (reqValid_i) begin
          nextState = COMPARE;
        end
      end
      COMPARE: begin
        if (hit_i) begin
          nextState = IDLE;
        end else if (victim_i.dirty) begin
          nextState = WRBACK;
        end else begin
          nextState = MISS;
        end
      end
      WRBACK: begin
        if (memWrReady_i) begin
          nextState = MISS;
        end
      end
      MISS: begin
        if (memRdReady_i) begin
          nextState = REFILL;
        end
      end
      REFILL: begin
        if (memRdLast_i) begin
          nextState = REPLACE;
        end
      end
      REPLACE: nextState = COMPARE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqLatch <= '0;
    end else if (curState == IDLE && reqValid_i) begin
      reqLatch <= req_i;
    end
  end

  assign reqReady_o  = (curState == IDLE);
  assign respValid_o = (curState == COMPARE) && hit_i;
  assign resp_o      = '{data: word_i, write: reqLatch.write};

  // write-back of the victim line
  assign memWrValid_o = (curState == WRBACK);
  assign memWr_o.addr = {victim_i.tag, index_o, {OffsetWidth{1'b0}}};
  assign memWr_o.line = victim_i.line;

  assign memRdValid_o = (curState == MISS);
  assign memRdAddr_o  = {tag_o, index_o, {OffsetWidth{1'b0}}};

  // beats fill the buffer from the low word up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (curState == MISS) begin
      beatCnt <= '0;
    end else if (curState == REFILL && memRdBeat_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (curState == REFILL && memRdBeat_i) begin
      refillBuf[beatCnt*WordWidth +: WordWidth] <= memRdData_i;
    end
  end

  // round-robin replacement
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimWay <= 1'b0;
    end else if (replaceEn) begin
      victimWay <= !victimWay;
    end
  end

  // shift into the byte lanes, upper bytes drop off
  assign storeWord = reqLatch.data << {reqLatch.addr[2:0], 3'b000};
  assign storeMask = reqLatch.mask << reqLatch.addr[2:0];
  assign storeLine = LineWidth'(storeWord) << (wordSel_o * WordWidth);
  assign storeLineMask = (LineWidth/8)'(storeMask) << (wordSel_o * MaskWidth);

  assign replaceEn = (curState == REPLACE);
  assign storeHit  = (curState == COMPARE) && hit_i && reqLatch.write;

  always_comb begin
    if (replaceEn) begin
      wrLine = refillBuf;
      wrMask = '1;
    end else begin
      wrLine = storeLine;
      wrMask = storeLineMask;
    end
  end

  assign wrEn0 = (replaceEn && !victimWay) || (storeHit && !hitWay_i);
  assign wrEn1 = (replaceEn && victimWay) || (storeHit && hitWay_i);

  assign wayWrite0_o = '{en: wrEn0, line: wrLine, mask: wrMask, tagUpdate: replaceEn};
  assign wayWrite1_o = '{en: wrEn1, line: wrLine, mask: wrMask, tagUpdate: replaceEn};

endmodule

/* hdl/dcacheTop.sv */
`timescale 1ns/1ps

module dcacheTop import dcachePkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 reqValid_i,
  input  cacheReq_t            req_i,
  output logic                 reqReady_o,
  output logic                 respValid_o,
  output cacheResp_t           resp_o,
  output logic                 memWrValid_o,
  output memReq_t              memWr_o,
  input  logic                 memWrReady_i,
  output logic                 memRdValid_o,
  output logic [AddrWidth-1:0] memRdAddr_o,
  input  logic                 memRdReady_i,
  input  logic [WordWidth-1:0] memRdData_i,
  input  logic                 memRdBeat_i,
  input  logic                 memRdLast_i
);

  logic [IndexWidth-1:0]           index;
  logic [TagWidth-1:0]             tag;
  logic [$clog2(BeatsPerLine)-1:0] wordSel;
  logic                            victimWay;
  logic                            hit;
  logic                            hitWay;
  logic [WordWidth-1:0]            word;
  wayLookup_t                      victim;
  wayLookup_t                      lookup0;
  wayLookup_t                      lookup1;
  wayWrite_t                       wayWrite0;
  wayWrite_t                       wayWrite1;

  cacheCtrl cacheCtrl_i (
    .clk, .rst_n, .reqValid_i, .req_i, .reqReady_o, .respValid_o, .resp_o,
    .index_o     (index),
    .tag_o       (tag),
    .wordSel_o   (wordSel),
    .victimWay_o (victimWay),
    .hit_i       (hit),
    .hitWay_i    (hitWay),
    .word_i      (word),
    .victim_i    (victim),
    .wayWrite0_o (wayWrite0),
    .wayWrite1_o (wayWrite1),
    .memWrValid_o, .memWr_o, .memWrReady_i,
    .memRdValid_o, .memRdAddr_o, .memRdReady_i,
    .memRdData_i, .memRdBeat_i, .memRdLast_i
  );

  cacheWay cacheWay0_i (
    .clk, .rst_n,
    .index_i  (index),
    .tag_i    (tag),
    .write_i  (wayWrite0),
    .lookup_o (lookup0)
  );

  cacheWay cacheWay1_i (
    .clk, .rst_n,
    .index_i  (index),
    .tag_i    (tag),
    .write_i  (wayWrite1),
    .lookup_o (lookup1)
  );

  wayMerge wayMerge_i (
    .way0_i      (lookup0),
    .way1_i      (lookup1),
    .wordSel_i   (wordSel),
    .victimWay_i (victimWay),
    .hit_o       (hit),
    .hitWay_o    (hitWay),
    .word_o      (word),
    .victim_o    (victim)
  );

endmodule

/* tb/clkGen.sv */
`timescale 1ns/1ps

module clkGen (
  output logic clk_o,
  output logic rst_n_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = !clk_o;
  end

  // reset held over three rising edges, released between edges
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* tb/dcacheChecker.sv */
`timescale 1ns/1ps

module dcacheChecker import dcachePkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 reqValid_i,
  input  logic                 reqReady_i,
  input  logic                 respValid_i,
  input  cacheResp_t           resp_i,
  input  logic                 memWrValid_i,
  input  logic                 memRdValid_i,
  input  logic [159:0]         expName_i,
  input  logic                 expWrite_i,
  input  logic [WordWidth-1:0] expData_i,
  input  logic                 expHit_i,
  output int                   passCount_o,
  output int                   failCount_o
);

  logic                 pending;
  logic                 resetChecked;
  logic                 idleReported;
  int                   cycle;
  int                   acceptCycle;
  logic [159:0]         curName;
  logic                 curWrite;
  logic [WordWidth-1:0] curData;
  logic                 curHit;

  initial begin
    passCount_o  = 0;
    failCount_o  = 0;
    pending      = 1'b0;
    resetChecked = 1'b0;
    idleReported = 1'b0;
    cycle        = 0;
    acceptCycle  = 0;
  end

  always @(posedge clk) begin : watch
    logic failed;
    failed = 1'b0;
    if (rst_n === 1'b1) begin
      // first edge out of reset
      if (!resetChecked) begin
        resetChecked = 1'b1;
        if (reqReady_i !== 1'b1 || respValid_i !== 1'b0 ||
            memWrValid_i !== 1'b0 || memRdValid_i !== 1'b0) begin
          $display("after reset reqReady_o is %b, respValid_o %b, memWrValid_o %b, memRdValid_o %b",
                   reqReady_i, respValid_i, memWrValid_i, memRdValid_i);
          failCount_o++;
        end else begin
          $display("pass reset");
          passCount_o++;
        end
      end
      // nothing in flight means the cache must be ready with the bus quiet
      if (!pending && !idleReported &&
          (reqReady_i !== 1'b1 || memWrValid_i !== 1'b0 || memRdValid_i !== 1'b0)) begin
        $display("the cache left idle with no request in flight");
        idleReported = 1'b1;
        failCount_o++;
      end
      if (respValid_i === 1'b1) begin
        if (!pending) begin
          $display("a response came with no request in flight");
          failCount_o++;
        end else begin
          if (resp_i.write !== curWrite) begin
            $display("Fail %0s expected write %b actual %b", curName, curWrite, resp_i.write);
            failed = 1'b1;
          end
          if (!curWrite && resp_i.data !== curData) begin
            $display("Fail %0s expected %h actual %h", curName, curData, resp_i.data);
            failed = 1'b1;
          end
          if (curHit && cycle - acceptCycle != 1) begin
            $display("%0s answered %0d cycles after acceptance, a hit answers after 1",
                     curName, cycle - acceptCycle);
            failed = 1'b1;
          end
          if (failed) begin
            failCount_o++;
          end else begin
            $display("pass %0s data %h", curName, resp_i.data);
            passCount_o++;
          end
          pending = 1'b0;
        end
      end
      // latch what the test in flight expects
      if (reqValid_i === 1'b1 && reqReady_i === 1'b1) begin
        pending     = 1'b1;
        acceptCycle = cycle;
        curName     = expName_i;
        curWrite    = expWrite_i;
        curData     = expData_i;
        curHit      = expHit_i;
      end
    end
    cycle++;
  end

endmodule

/* tb/dcacheTb.sv */
`timescale 1ns/1ps

module dcacheTb import dcachePkg::*; ();

  logic                 clk;
  logic                 rst_n;
  logic                 reqValid;
  cacheReq_t            req;
  logic                 reqReady;
  logic                 respValid;
  cacheResp_t           resp;
  logic                 memWrValid;
  memReq_t              memWr;
  logic                 memWrReady;
  logic                 memRdValid;
  logic [AddrWidth-1:0] memRdAddr;
  logic                 memRdReady;
  logic [WordWidth-1:0] memRdData;
  logic                 memRdBeat;
  logic                 memRdLast;
  logic [159:0]         expName;
  logic                 expWrite;
  logic [WordWidth-1:0] expData;
  logic                 expHit;
  int                   passCount;
  int                   failCount;
  int                   runErrors;
  logic [31:0]          lfsrState;
  // backing store holding only written-back words
  logic [WordWidth-1:0] memory [logic [AddrWidth-1:0]];

  clkGen clkGen_i (.clk_o(clk), .rst_n_o(rst_n));

  dcacheTop dcacheTop_i (
    .clk, .rst_n,
    .reqValid_i   (reqValid),
    .req_i        (req),
    .reqReady_o   (reqReady),
    .respValid_o  (respValid),
    .resp_o       (resp),
    .memWrValid_o (memWrValid),
    .memWr_o      (memWr),
    .memWrReady_i (memWrReady),
    .memRdValid_o (memRdValid),
    .memRdAddr_o  (memRdAddr),
    .memRdReady_i (memRdReady),
    .memRdData_i  (memRdData),
    .memRdBeat_i  (memRdBeat),
    .memRdLast_i  (memRdLast)
  );

  dcacheChecker dcacheChecker_i (
    .clk, .rst_n,
    .reqValid_i   (reqValid),
    .reqReady_i   (reqReady),
    .respValid_i  (respValid),
    .resp_i       (resp),
    .memWrValid_i (memWrValid),
    .memRdValid_i (memRdValid),
    .expName_i    (expName),
    .expWrite_i   (expWrite),
    .expData_i    (expData),
    .expHit_i     (expHit),
    .passCount_o  (passCount),
    .failCount_o  (failCount)
  );

  // fibonacci lfsr x^32 + x^22 + x^2 + x + 1 stepped once per bit
  task automatic drawBits(input int count, output int value);
    logic fb;
    value = 0;
    for (int i = 0; i < count; i++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      value = (value << 1) | fb;
    end
  endtask

  // untouched words hold their byte address xor a fixed pattern
  function automatic logic [WordWidth-1:0] readWord(input logic [AddrWidth-1:0] addr);
    if (memory.exists(addr)) begin
      return memory[addr];
    end
    return {32'h0, addr} ^ 64'h5a5a_0000_a5a5_0000;
  endfunction

  // burst memory with a random 0..3 cycle delay before each ready
  initial begin : memoryModel
    int                   delay;
    logic [AddrWidth-1:0] lineAddr;
    lfsrState  = 32'hd4c8_6cb4;
    memWrReady = 1'b0;
    memRdReady = 1'b0;
    memRdData  = '0;
    memRdBeat  = 1'b0;
    memRdLast  = 1'b0;
    forever begin
      @(negedge clk);
      if (memWrValid === 1'b1) begin
        drawBits(2, delay);
        repeat (delay) @(negedge clk);
        memWrReady = 1'b1;
        for (int i = 0; i < BeatsPerLine; i++) begin
          memory[memWr.addr + i * 8] = memWr.line[i*WordWidth +: WordWidth];
        end
        @(negedge clk);
        memWrReady = 1'b0;
      end else if (memRdValid === 1'b1) begin
        drawBits(2, delay);
        repeat (delay) @(negedge clk);
        lineAddr   = memRdAddr;
        memRdReady = 1'b1;
        @(negedge clk);
        memRdReady = 1'b0;
        for (int i = 0; i < BeatsPerLine; i++) begin
          memRdData = readWord(lineAddr + i * 8);
          memRdBeat = 1'b1;
          memRdLast = (i == BeatsPerLine - 1);
          @(negedge clk);
        end
        memRdBeat = 1'b0;
        memRdLast = 1'b0;
      end
    end
  end

  task automatic runTest(
    input  logic [159:0]         name,
    input  logic                 isStore,
    input  logic [AddrWidth-1:0] addr,
    input  logic [WordWidth-1:0] data,
    input  logic [MaskWidth-1:0] mask,
    input  logic [WordWidth-1:0] expValue,
    input  logic                 hitOnly,
    output logic                 stuck
  );
    int waitCycles;
    stuck = 1'b0;
    waitCycles = 0;
    while (reqReady !== 1'b1 && waitCycles < 50) begin
      @(negedge clk);
      waitCycles++;
    end
    if (reqReady !== 1'b1) begin
      $display("timeout in %0s waiting for reqReady_o", name);
      stuck = 1'b1;
    end else begin
      expName   = name;
      expWrite  = isStore;
      expData   = expValue;
      expHit    = hitOnly;
      req.write = isStore;
      req.addr  = addr;
      req.data  = data;
      req.mask  = mask;
      reqValid  = 1'b1;
      // taken on the rising edge in between
      @(negedge clk);
      reqValid = 1'b0;
      req      = '0;
      waitCycles = 0;
      while (respValid !== 1'b1 && waitCycles < 100) begin
        @(negedge clk);
        waitCycles++;
      end
      if (respValid !== 1'b1) begin
        $display("timeout in %0s waiting for respValid_o", name);
        stuck = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
  endtask

  initial begin : stimulus
    int                   fd;
    int                   code;
    int                   waitCycles;
    logic                 stopRun;
    logic                 stuck;
    logic [159:0]         token;
    logic [159:0]         opToken;
    logic [1023:0]        restOfLine;
    logic [AddrWidth-1:0] addr;
    logic [WordWidth-1:0] data;
    logic [MaskWidth-1:0] mask;
    logic [WordWidth-1:0] expValue;
    logic [3:0]           hitFlag;
    reqValid  = 1'b0;
    req       = '0;
    expName   = '0;
    expWrite  = 1'b0;
    expData   = '0;
    expHit    = 1'b0;
    runErrors = 0;
    stopRun   = 1'b0;
    fd = $fopen("tb/dcachePatterns.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/dcachePatterns.txt");
      runErrors++;
      stopRun = 1'b1;
    end
    waitCycles = 0;
    while (rst_n !== 1'b1 && waitCycles < 20) begin
      @(negedge clk);
      waitCycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      runErrors++;
      stopRun = 1'b1;
    end
    // idle cycles where the checker watches for stray activity
    repeat (4) @(negedge clk);
    while (!stopRun) begin
      code = $fscanf(fd, "%s", token);
      if (code != 1) begin
        stopRun = 1'b1;
      end else if (token == "#") begin
        code = $fgets(restOfLine, fd);
      end else begin
        code = $fscanf(fd, "%s %h %h %h %h %h", opToken, addr, data, mask, expValue, hitFlag);
        if (code != 6) begin
          $display("pattern line %0s is incomplete", token);
          runErrors++;
          stopRun = 1'b1;
        end else begin
          runTest(token, opToken == "st", addr, data, mask, expValue, hitFlag[0], stuck);
          if (stuck) begin
            runErrors++;
            stopRun = 1'b1;
          end
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    @(negedge clk);
    $display("tests passed %0d, failed %0d, run errors %0d", passCount, failCount, runErrors);
    if (failCount == 0 && runErrors == 0 && passCount > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* tb/dcachePatterns.txt */
# name op addr data mask expected hitCheck, op is ld or st, numbers in hex
# hitCheck 1 means the answer must come one cycle after acceptance
# set 0, cold miss, hits, offset store
coldLoad       ld 00001008 0000000000000000 00 5a5a0000a5a51008 0
hitLoad        ld 00001018 0000000000000000 00 5a5a0000a5a51018 1
storeOffset    st 00001013 1122334455667788 0f 0000000000000000 1
loadMerged     ld 00001010 0000000000000000 00 5a55667788a51010 1
# three more lines in set 0, the dirty line is written back and refilled
conflictA      ld 00001800 0000000000000000 00 5a5a0000a5a51800 0
conflictB      ld 00002008 0000000000000000 00 5a5a0000a5a52008 0
conflictC      ld 00002810 0000000000000000 00 5a5a0000a5a52810 0
reloadStored   ld 00001010 0000000000000000 00 5a55667788a51010 0
reloadOther    ld 00001008 0000000000000000 00 5a5a0000a5a51008 1
# set 9, store miss into way 1, then evict it dirty
storeMiss      st 00003126 cafef00ddeadbeef ff 0000000000000000 0
loadStoreMiss  ld 00003120 0000000000000000 00 beef0000a5a53120 1
loadUntouched  ld 00003128 0000000000000000 00 5a5a0000a5a53128 1
setNineFill    ld 00003920 0000000000000000 00 5a5a0000a5a53920 0
setNineEvict   ld 00004138 0000000000000000 00 5a5a0000a5a54138 0
setNineReload  ld 00003120 0000000000000000 00 beef0000a5a53120 0
setNineHit     ld 00004128 0000000000000000 00 5a5a0000a5a54128 1

/* filelist.f */
hdl/dcachePkg.sv
hdl/setArray.sv
hdl/cacheWay.sv
hdl/wayMerge.sv
hdl/cacheCtrl.sv
hdl/dcacheTop.sv
tb/clkGen.sv
tb/dcacheChecker.sv
tb/dcacheTb.sv
